// File: hw/exe_pkg.sv
/*
 * Shared widths, opcode and funct3 codes and the decoded record of the
 * reduced RV32I execution stage. Files refer to it by scoped names.
 */

package exe_pkg;

        localparam int XLEN       = 32;
        localparam int REG_ADDR_W = 5;

        // --------------------------------------------------
        // major opcodes, instr[6:0]
        // --------------------------------------------------
        localparam logic [6:0] OPC_OP     = 7'b0110011;
        localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
        localparam logic [6:0] OPC_BRANCH = 7'b1100011;
        localparam logic [6:0] OPC_LUI    = 7'b0110111;
        localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

        // alu funct3
        typedef enum logic [2:0] {
                ALU_ADD_SUB = 3'b000,
                ALU_SLL     = 3'b001,
                ALU_SLT     = 3'b010,
                ALU_SLTU    = 3'b011,
                ALU_XOR     = 3'b100,
                ALU_SRL_SRA = 3'b101,
                ALU_OR      = 3'b110,
                ALU_AND     = 3'b111
        } alu_f3_t;

        // branch funct3, codes 2 and 3 unused
        typedef enum logic [2:0] {
                BR_BEQ  = 3'b000,
                BR_BNE  = 3'b001,
                BR_BLT  = 3'b100,
                BR_BGE  = 3'b101,
                BR_BLTU = 3'b110,
                BR_BGEU = 3'b111
        } br_f3_t;

        typedef enum logic [1:0] {
                KIND_ALU    = 2'd0,
                KIND_BRANCH = 2'd1,
                KIND_UPPER  = 2'd2,
                KIND_NONE   = 2'd3
        } op_kind_t;

        // --------------------------------------------------
        // one buffer entry, 139 bits
        // --------------------------------------------------
        typedef struct packed {
                op_kind_t                kind;
                logic [2:0]              funct3;
                logic                    alt;     // SUB or SRA
                logic [XLEN-1:0]         x;       // rs1
                logic [XLEN-1:0]         y;       // rs2 or I-immediate
                logic [XLEN-1:0]         upper;   // LUI / AUIPC value
                logic [XLEN-1:0]         target;  // pc + B-immediate
                logic [REG_ADDR_W-1:0]   rd;
        } op_rec_t;

endpackage

// File: hw/operand_decode.sv
/*
 * Input side of the execution stage. Accepts one instruction per four-phase
 * req/ack cycle, decodes immediates and operands and pushes a record.
 */

`timescale 1ns/100ps

module operand_decode (
        input  logic                        clk,
        input  logic                        reset_n,
        input  logic                        in_req_i,
        input  logic [31:0]                 instr_i,
        input  logic [exe_pkg::XLEN-1:0]    pc_i,
        input  logic [exe_pkg::XLEN-1:0]    rs1_i,
        input  logic [exe_pkg::XLEN-1:0]    rs2_i,
        output logic                        in_ack_o,
        input  logic                        fifo_full_i,
        output logic                        push_o,
        output exe_pkg::op_rec_t            rec_o
);

        logic [6:0]                 opcode;
        logic [2:0]                 funct3;
        logic [exe_pkg::XLEN-1:0]   imm_i;
        logic [exe_pkg::XLEN-1:0]   imm_b;
        logic [exe_pkg::XLEN-1:0]   imm_u;
        logic                       is_op;
        logic                       is_op_imm;

        // --------------------------------------------------
        // input handshake
        // --------------------------------------------------
        // ack low means waiting for req, ack high holds until req is released
        assign push_o = in_req_i & ~in_ack_o & ~fifo_full_i;

        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        in_ack_o <= 1'b0;
                end else if (push_o) begin
                        in_ack_o <= 1'b1;
                end else if (!in_req_i) begin
                        in_ack_o <= 1'b0;
                end
        end

        // --------------------------------------------------
        // immediates
        // --------------------------------------------------
        assign opcode = instr_i[6:0];
        assign funct3 = instr_i[14:12];

        assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
        assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
        assign imm_u = {instr_i[31:12], 12'd0};

        assign is_op     = (opcode == exe_pkg::OPC_OP);
        assign is_op_imm = (opcode == exe_pkg::OPC_OP_IMM);

        // record built straight from the held inputs
        always_comb begin
                if (is_op || is_op_imm) begin
                        rec_o.kind = exe_pkg::KIND_ALU;
                end else if (opcode == exe_pkg::OPC_BRANCH) begin
                        rec_o.kind = exe_pkg::KIND_BRANCH;
                end else if (opcode == exe_pkg::OPC_LUI || opcode == exe_pkg::OPC_AUIPC) begin
                        rec_o.kind = exe_pkg::KIND_UPPER;
                end else begin
                        rec_o.kind = exe_pkg::KIND_NONE;
                end

                rec_o.funct3 = funct3;
                // bit 30 means SUB only on OP, SRA on both alu forms
                rec_o.alt    = instr_i[30] & (is_op |
                               (is_op_imm & (funct3 == exe_pkg::ALU_SRL_SRA)));
                rec_o.x      = rs1_i;
                rec_o.y      = is_op_imm ? imm_i : rs2_i;
                rec_o.upper  = (opcode == exe_pkg::OPC_AUIPC) ? pc_i + imm_u : imm_u;
                rec_o.target = pc_i + imm_b;
                rec_o.rd     = instr_i[11:7];
        end

endmodule

// File: hw/op_fifo.sv
/*
 * Circular buffer of decoded records between decode and execute.
 * Single-cycle push/pop strobes, head is read combinationally.
 */

`timescale 1ns/100ps

module op_fifo #(
        parameter int DEPTH = 4
) (
        input  logic                clk,
        input  logic                reset_n,
        input  logic                push_i,
        input  exe_pkg::op_rec_t    wdata_i,
        input  logic                pop_i,
        output exe_pkg::op_rec_t    rdata_o,
        output logic                full_o,
        output logic                empty_o
);

        localparam int AW = $clog2(DEPTH);

        exe_pkg::op_rec_t   mem [DEPTH];
        logic [AW-1:0]      wr_ptr;
        logic [AW-1:0]      rd_ptr;
        logic [AW:0]        count;

        assign full_o  = (count == (AW+1)'(DEPTH));
        assign empty_o = (count == '0);
        assign rdata_o = mem[rd_ptr];

        // storage
        always_ff @(posedge clk) begin
                if (push_i) begin
                        mem[wr_ptr] <= wdata_i;
                end
        end

        // --------------------------------------------------
        // pointers and occupancy
        // --------------------------------------------------
        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push_i) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (pop_i) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        // simultaneous push and pop leaves count alone
                        if (push_i && !pop_i) begin
                                count <= count + 1'b1;
                        end else if (pop_i && !push_i) begin
                                count <= count - 1'b1;
                        end
                end
        end

endmodule

// File: hw/alu_branch_exec.sv
/*
 * Execute side. Pops one record at a time, computes the ALU, upper-immediate
 * or branch outcome and presents it by a four-phase req/ack handshake.
 */

`timescale 1ns/100ps

module alu_branch_exec (
        input  logic                                clk,
        input  logic                                reset_n,
        input  logic                                empty_i,
        input  exe_pkg::op_rec_t                    rec_i,
        output logic                                pop_o,
        output logic                                res_req_o,
        input  logic                                res_ack_i,
        output logic [exe_pkg::REG_ADDR_W-1:0]      rd_addr_o,
        output logic                                write_rd_o,
        output logic [exe_pkg::XLEN-1:0]            result_o,
        output logic                                branch_taken_o,
        output logic [exe_pkg::XLEN-1:0]            branch_target_o
);

        typedef enum logic [1:0] {
                OUT_IDLE,
                OUT_REQ,
                OUT_RELEASE
        } out_state_t;

        out_state_t                 state;
        logic [4:0]                 shamt;
        logic                       eq;
        logic                       lt;
        logic                       ltu;
        logic [exe_pkg::XLEN-1:0]   sra_out;
        logic [exe_pkg::XLEN-1:0]   alu_out;
        logic                       br_taken;
        logic [exe_pkg::XLEN-1:0]   res_d;
        logic                       wr_d;

        // --------------------------------------------------
        // ALU
        // --------------------------------------------------
        assign shamt = rec_i.y[4:0];
        assign eq    = (rec_i.x == rec_i.y);
        assign lt    = ($signed(rec_i.x) < $signed(rec_i.y));
        assign ltu   = (rec_i.x < rec_i.y);

        // sign-filling shift for SRA and SRAI
        assign sra_out = $signed(rec_i.x) >>> shamt;

        always_comb begin
                case (rec_i.funct3)
                        exe_pkg::ALU_ADD_SUB: alu_out = rec_i.alt ? rec_i.x - rec_i.y
                                                                  : rec_i.x + rec_i.y;
                        exe_pkg::ALU_SLL:     alu_out = rec_i.x << shamt;
                        exe_pkg::ALU_SLT:     alu_out = {31'd0, lt};
                        exe_pkg::ALU_SLTU:    alu_out = {31'd0, ltu};
                        exe_pkg::ALU_XOR:     alu_out = rec_i.x ^ rec_i.y;
                        exe_pkg::ALU_SRL_SRA: alu_out = rec_i.alt ? sra_out
                                                                  : rec_i.x >> shamt;
                        exe_pkg::ALU_OR:      alu_out = rec_i.x | rec_i.y;
                        default:              alu_out = rec_i.x & rec_i.y;
                endcase
        end

        // branch decision shares the compare results
        always_comb begin
                case (rec_i.funct3)
                        exe_pkg::BR_BEQ:  br_taken = eq;
                        exe_pkg::BR_BNE:  br_taken = ~eq;
                        exe_pkg::BR_BLT:  br_taken = lt;
                        exe_pkg::BR_BGE:  br_taken = ~lt;
                        exe_pkg::BR_BLTU: br_taken = ltu;
                        exe_pkg::BR_BGEU: br_taken = ~ltu;
                        default:          br_taken = 1'b0;
                endcase
        end

        always_comb begin
                case (rec_i.kind)
                        exe_pkg::KIND_ALU:   res_d = alu_out;
                        exe_pkg::KIND_UPPER: res_d = rec_i.upper;
                        default:             res_d = '0;
                endcase
                wr_d = (rec_i.kind == exe_pkg::KIND_ALU) || (rec_i.kind == exe_pkg::KIND_UPPER);
        end

        // --------------------------------------------------
        // output handshake and result registers
        // --------------------------------------------------
        assign pop_o = (state == OUT_IDLE) & ~empty_i;

        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        state           <= OUT_IDLE;
                        res_req_o       <= 1'b0;
                        rd_addr_o       <= '0;
                        write_rd_o      <= 1'b0;
                        result_o        <= '0;
                        branch_taken_o  <= 1'b0;
                        branch_target_o <= '0;
                end else begin
                        case (state)
                                OUT_IDLE: begin
                                        if (pop_o) begin
                                                state           <= OUT_REQ;
                                                res_req_o       <= 1'b1;
                                                rd_addr_o       <= wr_d ? rec_i.rd : '0;
                                                write_rd_o      <= wr_d;
                                                result_o        <= res_d;
                                                branch_taken_o  <= (rec_i.kind == exe_pkg::KIND_BRANCH)
                                                                   & br_taken;
                                                branch_target_o <= (rec_i.kind == exe_pkg::KIND_BRANCH)
                                                                   ? rec_i.target : '0;
                                        end
                                end
                                OUT_REQ: begin
                                        if (res_ack_i) begin
                                                state     <= OUT_RELEASE;
                                                res_req_o <= 1'b0;
                                        end
                                end
                                default: begin
                                        // wait for the sink to drop ack
                                        if (!res_ack_i) begin
                                                state <= OUT_IDLE;
                                        end
                                end
                        endcase
                end
        end

endmodule

// File: hw/exe_top.sv
/*
 * Top level of the reduced RV32I execution stage. Connects decode, the
 * operand buffer and execute, and sets the buffer depth.
 */

`timescale 1ns/100ps

module exe_top #(
        parameter int DEPTH = 4
) (
        input  logic                                clk,
        input  logic                                reset_n,
        input  logic                                in_req_i,
        output logic                                in_ack_o,
        input  logic [31:0]                         instr_i,
        input  logic [exe_pkg::XLEN-1:0]            pc_i,
        input  logic [exe_pkg::XLEN-1:0]            rs1_i,
        input  logic [exe_pkg::XLEN-1:0]            rs2_i,
        output logic                                res_req_o,
        input  logic                                res_ack_i,
        output logic [exe_pkg::REG_ADDR_W-1:0]      rd_addr_o,
        output logic                                write_rd_o,
        output logic [exe_pkg::XLEN-1:0]            result_o,
        output logic                                branch_taken_o,
        output logic [exe_pkg::XLEN-1:0]            branch_target_o
);

        logic               push;
        logic               pop;
        logic               fifo_full;
        logic               fifo_empty;
        exe_pkg::op_rec_t   push_rec;
        exe_pkg::op_rec_t   head_rec;

        operand_decode u_decode (
                .clk         (clk),
                .reset_n     (reset_n),
                .in_req_i    (in_req_i),
                .instr_i     (instr_i),
                .pc_i        (pc_i),
                .rs1_i       (rs1_i),
                .rs2_i       (rs2_i),
                .in_ack_o    (in_ack_o),
                .fifo_full_i (fifo_full),
                .push_o      (push),
                .rec_o       (push_rec)
        );

        op_fifo #(
                .DEPTH (DEPTH)
        ) u_fifo (
                .clk     (clk),
                .reset_n (reset_n),
                .push_i  (push),
                .wdata_i (push_rec),
                .pop_i   (pop),
                .rdata_o (head_rec),
                .full_o  (fifo_full),
                .empty_o (fifo_empty)
        );

        alu_branch_exec u_exec (
                .clk             (clk),
                .reset_n         (reset_n),
                .empty_i         (fifo_empty),
                .rec_i           (head_rec),
                .pop_o           (pop),
                .res_req_o       (res_req_o),
                .res_ack_i       (res_ack_i),
                .rd_addr_o       (rd_addr_o),
                .write_rd_o      (write_rd_o),
                .result_o        (result_o),
                .branch_taken_o  (branch_taken_o),
                .branch_target_o (branch_target_o)
        );

endmodule

// File: verif/tb_exe.sv
/*
 * Testbench of the execution stage. Reads verif/exe_trace.txt, sends each
 * instruction by the input handshake and checks results in trace order.
 */

`timescale 1ns/100ps

module tb_exe;

        localparam int MAX_LINES = 64;
        localparam int TIMEOUT   = 200;

        logic           clk;
        logic           reset_n;
        logic           in_req_i;
        logic           in_ack_o;
        logic [31:0]    instr_i;
        logic [31:0]    pc_i;
        logic [31:0]    rs1_i;
        logic [31:0]    rs2_i;
        logic           res_req_o;
        logic           res_ack_i;
        logic [4:0]     rd_addr_o;
        logic           write_rd_o;
        logic [31:0]    result_o;
        logic           branch_taken_o;
        logic [31:0]    branch_target_o;

        // trace columns
        logic [31:0]    tr_instr [MAX_LINES];
        logic [31:0]    tr_pc [MAX_LINES];
        logic [31:0]    tr_rs1 [MAX_LINES];
        logic [31:0]    tr_rs2 [MAX_LINES];
        logic [31:0]    tr_rd [MAX_LINES];
        logic [31:0]    tr_wr [MAX_LINES];
        logic [31:0]    tr_result [MAX_LINES];
        logic [31:0]    tr_taken [MAX_LINES];
        logic [31:0]    tr_target [MAX_LINES];

        int             n_lines;
        int             mismatches;
        int             proto_errors;
        int             other_errors;
        bit             abort;
        logic           prev_req;
        logic           prev_ack;
        logic           prev_res_req;
        logic           prev_res_ack;

        exe_top #(
                .DEPTH (4)
        ) uut (
                .clk             (clk),
                .reset_n         (reset_n),
                .in_req_i        (in_req_i),
                .in_ack_o        (in_ack_o),
                .instr_i         (instr_i),
                .pc_i            (pc_i),
                .rs1_i           (rs1_i),
                .rs2_i           (rs2_i),
                .res_req_o       (res_req_o),
                .res_ack_i       (res_ack_i),
                .rd_addr_o       (rd_addr_o),
                .write_rd_o      (write_rd_o),
                .result_o        (result_o),
                .branch_taken_o  (branch_taken_o),
                .branch_target_o (branch_target_o)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        task automatic compare_value(input string name, input int line,
                                     input logic [31:0] got, input logic [31:0] exp);
                if (got !== exp) begin
                        $display("ERR %s line %0d: got %h, expected %h", name, line, got, exp);
                        mismatches++;
                end
        endtask

        task automatic load_trace;
                int fd;
                int n;
                reg [8*200-1:0] line;
                logic [31:0] f [9];
                fd = $fopen("verif/exe_trace.txt", "r");
                if (fd == 0) begin
                        $display("could not open the trace file verif/exe_trace.txt");
                        other_errors++;
                        return;
                end
                while (!$feof(fd)) begin
                        line = '0;
                        void'($fgets(line, fd));
                        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                    f[3], f[4], f[5], f[6], f[7], f[8]);
                        // comment and blank lines give no values
                        if (n == 9 && n_lines < MAX_LINES) begin
                                tr_instr[n_lines]  = f[0];
                                tr_pc[n_lines]     = f[1];
                                tr_rs1[n_lines]    = f[2];
                                tr_rs2[n_lines]    = f[3];
                                tr_rd[n_lines]     = f[4];
                                tr_wr[n_lines]     = f[5];
                                tr_result[n_lines] = f[6];
                                tr_taken[n_lines]  = f[7];
                                tr_target[n_lines] = f[8];
                                n_lines++;
                        end
                end
                $fclose(fd);
                if (n_lines == 0) begin
                        $display("the trace file holds no instruction lines");
                        other_errors++;
                end
        endtask

        // both handshakes idle and result fields cleared after reset
        task automatic check_idle;
                repeat (4) begin
                        @(negedge clk);
                        compare_value("in_ack_o", -1, 32'(in_ack_o), 32'd0);
                        compare_value("res_req_o", -1, 32'(res_req_o), 32'd0);
                end
                compare_value("rd_addr_o", -1, 32'(rd_addr_o), 32'd0);
                compare_value("result_o", -1, result_o, 32'd0);
                compare_value("write_rd_o", -1, 32'(write_rd_o), 32'd0);
                compare_value("branch_taken_o", -1, 32'(branch_taken_o), 32'd0);
                compare_value("branch_target_o", -1, branch_target_o, 32'd0);
        endtask

        // --------------------------------------------------
        // input side, one four-phase cycle per trace line
        // --------------------------------------------------
        task automatic send_all;
                int i;
                int waited;
                for (i = 0; i < n_lines && !abort; i++) begin
                        instr_i  = tr_instr[i];
                        pc_i     = tr_pc[i];
                        rs1_i    = tr_rs1[i];
                        rs2_i    = tr_rs2[i];
                        in_req_i = 1'b1;
                        waited   = 0;
                        do begin
                                @(negedge clk);
                                waited++;
                        end while (in_ack_o !== 1'b1 && waited < TIMEOUT);
                        if (in_ack_o !== 1'b1) begin
                                $display("timeout: in_ack_o never rose for trace line %0d", i);
                                other_errors++;
                                abort = 1'b1;
                        end
                        in_req_i = 1'b0;
                        waited   = 0;
                        while (in_ack_o !== 1'b0 && waited < TIMEOUT) begin
                                @(negedge clk);
                                waited++;
                        end
                        if (in_ack_o !== 1'b0) begin
                                $display("timeout: in_ack_o stayed high after line %0d", i);
                                other_errors++;
                                abort = 1'b1;
                        end
                end
        endtask

        // --------------------------------------------------
        // output side, random ack delay of 0 to 6 cycles
        // --------------------------------------------------
        task automatic receive_all;
                int i;
                int waited;
                int delay;
                for (i = 0; i < n_lines && !abort; i++) begin
                        waited = 0;
                        while (res_req_o !== 1'b1 && waited < TIMEOUT) begin
                                @(negedge clk);
                                waited++;
                        end
                        if (res_req_o !== 1'b1) begin
                                $display("timeout: no result for trace line %0d", i);
                                other_errors++;
                                abort = 1'b1;
                        end else begin
                                compare_value("rd_addr_o", i, 32'(rd_addr_o), tr_rd[i]);
                                compare_value("write_rd_o", i, 32'(write_rd_o), tr_wr[i]);
                                compare_value("result_o", i, result_o, tr_result[i]);
                                compare_value("branch_taken_o", i, 32'(branch_taken_o),
                                              tr_taken[i]);
                                compare_value("branch_target_o", i, branch_target_o,
                                              tr_target[i]);
                                delay = $urandom % 7;
                                repeat (delay) @(negedge clk);
                                res_ack_i = 1'b1;
                                waited    = 0;
                                do begin
                                        @(negedge clk);
                                        waited++;
                                end while (res_req_o !== 1'b0 && waited < TIMEOUT);
                                if (res_req_o !== 1'b0) begin
                                        $display("timeout: res_req_o stayed high on line %0d", i);
                                        other_errors++;
                                        abort = 1'b1;
                                end
                                res_ack_i = 1'b0;
                        end
                end
        endtask

        // protocol monitor on the values held just before each edge
        always @(posedge clk) begin
                if (reset_n) begin
                        if (in_ack_o && !prev_ack && !prev_req) begin
                                $display("protocol: in_ack_o rose while in_req_i was low");
                                proto_errors++;
                        end
                        if (!in_ack_o && prev_ack && prev_req) begin
                                $display("protocol: in_ack_o fell while in_req_i was high");
                                proto_errors++;
                        end
                        if (!res_req_o && prev_res_req && !prev_res_ack) begin
                                $display("protocol: res_req_o fell before res_ack_i was high");
                                proto_errors++;
                        end
                end
                prev_req     = in_req_i;
                prev_ack     = in_ack_o;
                prev_res_req = res_req_o;
                prev_res_ack = res_ack_i;
        end

        initial begin
                void'($urandom(38039));
                reset_n      = 1'b0;
                in_req_i     = 1'b0;
                instr_i      = '0;
                pc_i         = '0;
                rs1_i        = '0;
                rs2_i        = '0;
                res_ack_i    = 1'b0;
                n_lines      = 0;
                mismatches   = 0;
                proto_errors = 0;
                other_errors = 0;
                abort        = 1'b0;
                prev_req     = 1'b0;
                prev_ack     = 1'b0;
                prev_res_req = 1'b0;
                prev_res_ack = 1'b0;
                load_trace();
                repeat (3) @(posedge clk);
                @(negedge clk);
                reset_n = 1'b1;
                check_idle();
                if (n_lines > 0) begin
                        fork
                                send_all();
                                receive_all();
                        join
                end
                // one result per line, nothing more
                if (!abort) begin
                        repeat (20) @(negedge clk);
                        if (res_req_o !== 1'b0) begin
                                $display("an extra result appeared after the last trace line");
                                other_errors++;
                        end
                end
                $display("errors: %0d mismatches, %0d protocol, %0d other",
                         mismatches, proto_errors, other_errors);
                if (mismatches == 0 && proto_errors == 0 && other_errors == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

// File: verif/exe_trace.txt
# instr    pc       rs1      rs2      rd wr result   tk target
# all hex; expected rd, write_rd, result, taken and target follow the four inputs
002081B3 00000100 00000005 00000007 03 1 0000000C 0 00000000
40208233 00000104 00000005 00000007 04 1 FFFFFFFE 0 00000000
002092B3 00000108 00000003 00000024 05 1 00000030 0 00000000
0020A333 0000010C FFFFFFF0 00000001 06 1 00000001 0 00000000
0020B3B3 00000110 FFFFFFF0 00000001 07 1 00000000 0 00000000
0020C433 00000114 F0F0F0F0 0FF00FF0 08 1 FF00FF00 0 00000000
0020D4B3 00000118 80000000 00000004 09 1 08000000 0 00000000
4020D533 0000011C 80000000 00000004 0A 1 F8000000 0 00000000
0020E5B3 00000120 12340000 00005678 0B 1 12345678 0 00000000
0020F633 00000124 FFFF0000 12345678 0C 1 12340000 0 00000000
FFF08693 00000128 00000010 DEADBEEF 0D 1 0000000F 0 00000000
7FF08713 0000012C 00000001 DEADBEEF 0E 1 00000800 0 00000000
FFB0A793 00000130 FFFFFFF0 00000000 0F 1 00000001 0 00000000
00809913 00000134 000000AB 00000000 12 1 0000AB00 0 00000000
0040D993 00000138 F0000000 00000000 13 1 0F000000 0 00000000
4040DA13 0000013C F0000000 00000000 14 1 FF000000 0 00000000
12345BB7 00000140 00000000 00000000 17 1 12345000 0 00000000
00010C17 00000234 00000000 00000000 18 1 00010234 0 00000000
FE208CE3 00000400 00000005 00000005 00 0 00000000 1 000003F8
00208863 00000404 00000005 00000006 00 0 00000000 0 00000414
00209863 00000408 00000005 00000006 00 0 00000000 1 00000418
00209863 0000040C 00000007 00000007 00 0 00000000 0 0000041C
0020C863 00000410 FFFFFFFF 00000001 00 0 00000000 1 00000420
0020C863 00000414 00000001 FFFFFFFF 00 0 00000000 0 00000424
0020D863 00000418 00000001 FFFFFFFF 00 0 00000000 1 00000428
0020D863 0000041C FFFFFFFF 00000001 00 0 00000000 0 0000042C
0020E863 00000420 00000001 FFFFFFFF 00 0 00000000 1 00000430
0020E863 00000424 FFFFFFFF 00000001 00 0 00000000 0 00000434
0020F863 00000428 FFFFFFFF 00000001 00 0 00000000 1 00000438
0020F863 0000042C 00000001 FFFFFFFF 00 0 00000000 0 0000043C
0020A863 00000430 00000005 00000005 00 0 00000000 0 00000440
0000050B 00000434 00000001 00000002 00 0 00000000 0 00000000

// File: tb.f
hw/exe_pkg.sv
hw/operand_decode.sv
hw/op_fifo.sv
hw/alu_branch_exec.sv
hw/exe_top.sv
verif/tb_exe.sv

// File: run_sim.sh
#!/bin/sh
# builds tb_exe with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_exe -Mdir obj_dir -f tb.f

out=$(./obj_dir/Vtb_exe)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
        exit 0
else
        exit 1
fi
